//--- spi_dma_bridge.f
+incdir+testbench
verilog/spi_dma_pkg.sv
verilog/axil_slave_port.sv
verilog/spi_dma_regs.sv
verilog/spi_byte_engine.sv
verilog/spi_dma_bridge.sv
testbench/tb_spi_dma_bridge.sv

//--- Bender.yml
package:
  name: spi_dma_bridge

sources:
  - files:
      - verilog/spi_dma_pkg.sv
      - verilog/axil_slave_port.sv
      - verilog/spi_dma_regs.sv
      - verilog/spi_byte_engine.sv
      - verilog/spi_dma_bridge.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_spi_dma_bridge.sv

//--- testbench/spi_dma_tests.svh
// Directed test tasks, transfer helpers and typed compare tasks for the SPI bridge testbench
`ifndef spi_dma_tests_svh
`define spi_dma_tests_svh

task automatic check_data(input string name, input logic [axil_data_w-1:0] expected,
                          input logic [axil_data_w-1:0] actual);
    if (actual !== expected) begin
        $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_byte(input string name, input logic [byte_w-1:0] expected,
                          input logic [byte_w-1:0] actual);
    if (actual !== expected) begin
        $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_resp(input string name, input logic [1:0] expected,
                          input logic [1:0] actual);
    if (actual !== expected) begin
        $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic flag_error(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
endtask

task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("%s: passed", name);
        tests_passed++;
    end else begin
        $display("%s: failed with %0d errors", name, error_count - errors_before);
        tests_failed++;
    end
endtask

task automatic read_check(input string name, input logic [axil_addr_w-1:0] addr,
                          input logic [axil_data_w-1:0] expected);
    logic [axil_data_w-1:0] data;
    axil_read(addr, data);
    check_data(name, expected, data);
endtask

task automatic poll_reg(input logic [axil_addr_w-1:0] addr,
                        input logic [axil_data_w-1:0] value);
    logic [axil_data_w-1:0] data;
    do begin
        axil_read(addr, data);
    end while (data !== value);
endtask

task automatic start_transfer(input logic [axil_data_w-1:0] len);
    axil_write(addr_length, len);
    axil_write(addr_start, 1);
endtask

task automatic send_byte(input logic [byte_w-1:0] tx);
    poll_reg(addr_ready_out, 1);
    axil_write(addr_data_in, axil_data_w'(tx));
    axil_write(addr_valid_in, 1);
endtask

// Received byte against the model, transmitted byte against the capture
task automatic take_byte(input string name, input logic [byte_w-1:0] tx);
    logic [axil_data_w-1:0] data;
    poll_reg(addr_valid_out, 1);
    axil_read(addr_data_out, data);
    if ((sent_q.size() == 0) || (captured_q.size() == 0)) begin
        flag_error({name, ": the SPI slave model did not see a complete byte"});
    end else begin
        check_byte({name, "/miso"}, sent_q.pop_front(), data[byte_w-1:0]);
        check_byte({name, "/mosi"}, tx, captured_q.pop_front());
    end
    axil_write(addr_ready_in, 1);
    axil_write(addr_ready_in, 0);
endtask

task automatic finish_transfer(input string name);
    poll_reg(addr_busy, 0);
    read_check({name, "/done"}, addr_done, 1);
    check_data({name, "/cs_n"}, 1, axil_data_w'(cs_n));
endtask

task automatic reset_state();
    int errors_before;
    errors_before = error_count;
    test_name     = "reset_state";
    check_data("reset_state/cs_n", 1, axil_data_w'(cs_n));
    check_data("reset_state/sclk", 0, axil_data_w'(sclk));
    check_data("reset_state/mosi", 0, axil_data_w'(mosi));
    read_check("reset_state/busy", addr_busy, 0);
    read_check("reset_state/done", addr_done, 0);
    read_check("reset_state/ready_out", addr_ready_out, 0);
    read_check("reset_state/valid_out", addr_valid_out, 0);
    read_check("reset_state/length", addr_length, 0);
    read_check("reset_state/unmapped", 5'h1E, 0);
    report_test("reset_state", errors_before);
endtask

task automatic length_register();
    int errors_before;
    errors_before = error_count;
    test_name     = "length_register";
    axil_write(addr_length, 16'h1234);
    read_check("length_register/readback", addr_length, 16'h1234);
    start_transfer(0);
    read_check("length_register/busy", addr_busy, 0);
    check_data("length_register/cs_n", 1, axil_data_w'(cs_n));
    report_test("length_register", errors_before);
endtask

task automatic single_byte_transfer();
    int errors_before;
    errors_before = error_count;
    test_name     = "single_byte_transfer";
    start_transfer(1);
    send_byte(8'hA5);
    take_byte("single_byte_transfer", 8'hA5);
    finish_transfer("single_byte_transfer");
    read_check("single_byte_transfer/busy", addr_busy, 0);
    report_test("single_byte_transfer", errors_before);
endtask

task automatic three_byte_transfer();
    int errors_before;
    int cs_before;
    int rises_before;
    logic [byte_w-1:0] tx;
    errors_before = error_count;
    test_name     = "three_byte_transfer";
    cs_before     = cs_errors;
    rises_before  = cs_rises;
    start_transfer(3);
    read_check("three_byte_transfer/done_cleared", addr_done, 0);
    for (int i = 0; i < 3; i++) begin
        tx = byte_w'($urandom);
        send_byte(tx);
        take_byte("three_byte_transfer", tx);
    end
    finish_transfer("three_byte_transfer");
    // sclk edges seen with cs_n high
    check_data("three_byte_transfer/cs_n_low", 0, axil_data_w'(cs_errors - cs_before));
    // Only the final release, none between bytes
    check_data("three_byte_transfer/cs_n_rises", 1, axil_data_w'(cs_rises - rises_before));
    report_test("three_byte_transfer", errors_before);
endtask

task automatic back_pressure();
    int errors_before;
    int edges_before;
    logic [byte_w-1:0] rx_expected;
    errors_before = error_count;
    test_name     = "back_pressure";
    start_transfer(2);
    send_byte(8'h3C);
    poll_reg(addr_valid_out, 1);
    edges_before = sclk_edges;
    rx_expected  = '0;
    if (sent_q.size() == 0) begin
        flag_error("back_pressure: no byte was sent by the SPI slave model");
    end else begin
        rx_expected = sent_q[0];
    end
    repeat (4) begin
        read_check("back_pressure/valid_out", addr_valid_out, 1);
        read_check("back_pressure/data_out", addr_data_out, axil_data_w'(rx_expected));
        read_check("back_pressure/busy", addr_busy, 1);
    end
    check_data("back_pressure/sclk_edges", axil_data_w'(edges_before),
               axil_data_w'(sclk_edges));
    take_byte("back_pressure", 8'h3C);
    send_byte(8'hC3);
    take_byte("back_pressure", 8'hC3);
    finish_transfer("back_pressure");
    report_test("back_pressure", errors_before);
endtask

`endif

//--- testbench/tb_spi_dma_bridge.sv
// Testbench top with clock, reset, DUT, SPI slave model, watchdog, AXI4-Lite driver and summary
`timescale 1ns/1ps

module tb_spi_dma_bridge
    import spi_dma_pkg::*;
();

    localparam int clk_period      = 40;
    localparam int num_tests       = 5;
    localparam int total_bytes     = 6;
    localparam int poll_margin     = 600;
    localparam int watchdog_cycles = total_bytes * 16 + num_tests * poll_margin;

    logic                   S_AXI_ACLK = 1'b0;
    logic                   S_AXI_ARESETN;
    logic [axil_addr_w-1:0] S_AXI_AWADDR;
    logic                   S_AXI_AWVALID;
    logic                   S_AXI_AWREADY;
    logic [axil_data_w-1:0] S_AXI_WDATA;
    logic                   S_AXI_WVALID;
    logic                   S_AXI_WREADY;
    logic [1:0]             S_AXI_BRESP;
    logic                   S_AXI_BVALID;
    logic                   S_AXI_BREADY;
    logic [axil_addr_w-1:0] S_AXI_ARADDR;
    logic                   S_AXI_ARVALID;
    logic                   S_AXI_ARREADY;
    logic [axil_data_w-1:0] S_AXI_RDATA;
    logic [1:0]             S_AXI_RRESP;
    logic                   S_AXI_RVALID;
    logic                   S_AXI_RREADY;
    logic                   sclk;
    logic                   cs_n;
    logic                   mosi;
    logic                   miso;

    // SPI slave model state
    logic [byte_w-1:0] sent_q[$];
    logic [byte_w-1:0] captured_q[$];
    logic [byte_w-1:0] slave_tx;
    logic [byte_w-1:0] slave_rx;
    int bit_idx      = 0;
    int sclk_edges   = 0;
    int cs_errors    = 0;
    int cs_rises     = 0;
    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    string test_name = "";

    always #(clk_period / 2) S_AXI_ACLK = !S_AXI_ACLK;

    spi_dma_bridge dut (.*);

    // New random byte each time chip select drops
    always @(negedge cs_n) begin
        #1;
        slave_tx = byte_w'($urandom);
        bit_idx  = 0;
        miso     = slave_tx[byte_w-1];
    end

    always @(posedge cs_n) begin
        cs_rises++;
    end

    always @(posedge sclk) begin
        sclk_edges++;
        if (cs_n !== 1'b0) begin
            cs_errors++;
        end
        slave_rx = {slave_rx[byte_w-2:0], mosi};
        bit_idx++;
        if (bit_idx == byte_w) begin
            sent_q.push_back(slave_tx);
            captured_q.push_back(slave_rx);
            bit_idx = 0;
        end
    end

    // Next bit on the falling edge, fresh byte after the eighth bit
    always @(negedge sclk) begin
        sclk_edges++;
        #1;
        if (!cs_n) begin
            if (bit_idx == 0) begin
                slave_tx = byte_w'($urandom);
            end
            miso = slave_tx[byte_w-1-bit_idx];
        end
    end

    task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                              input logic [axil_data_w-1:0] data);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
            #1;
        end while (!S_AXI_AWREADY);
        if (S_AXI_WREADY !== 1'b1) begin
            flag_error({test_name, ": WREADY did not rise together with AWREADY"});
        end
        @(posedge S_AXI_ACLK);
        #1;
        if (S_AXI_BVALID !== 1'b1) begin
            flag_error({test_name, ": no write response after the write handshake"});
        end
        check_resp({test_name, "/bresp"}, axil_resp_okay, S_AXI_BRESP);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr,
                             output logic [axil_data_w-1:0] data);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        do begin
            @(posedge S_AXI_ACLK);
            #1;
        end while (!S_AXI_ARREADY);
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARVALID = 1'b0;
        if (S_AXI_RVALID !== 1'b1) begin
            flag_error({test_name, ": no read data after the address handshake"});
        end
        check_resp({test_name, "/rresp"}, axil_resp_okay, S_AXI_RRESP);
        data          = S_AXI_RDATA;
        S_AXI_RREADY  = 1'b1;
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_RREADY = 1'b0;
    endtask

    `include "spi_dma_tests.svh"

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: run timed out after %0d clock cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h229a));
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        miso          = 1'b0;
        repeat (5) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        @(posedge S_AXI_ACLK);
        #1;
        reset_state();
        length_register();
        single_byte_transfer();
        three_byte_transfer();
        back_pressure();
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if ((error_count == 0) && (tests_failed == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/spi_dma_bridge.sv
// Top level of the AXI4-Lite SPI master with byte handshake registers
`timescale 1ns/1ps

module spi_dma_bridge
    import spi_dma_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,

    input  logic [axil_addr_w-1:0] S_AXI_AWADDR,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    input  logic [axil_data_w-1:0] S_AXI_WDATA,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,

    input  logic [axil_addr_w-1:0] S_AXI_ARADDR,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    output logic [axil_data_w-1:0] S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY,

    output logic                   sclk,
    output logic                   cs_n,
    output logic                   mosi,
    input  logic                   miso
);

    logic                   wr_en;
    reg_addr_e              wr_addr;
    logic [axil_data_w-1:0] wr_data;
    logic                   rd_en;
    reg_addr_e              rd_addr;
    logic [axil_data_w-1:0] rd_data;

    logic                   start;
    logic [len_w-1:0]       length;
    logic [byte_w-1:0]      tx_byte;
    logic                   tx_valid;
    logic                   rx_ready;
    logic                   tx_ready;
    logic [byte_w-1:0]      rx_byte;
    logic                   rx_valid;
    logic                   busy;
    logic                   done;

    axil_slave_port u_axil_slave_port (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    spi_dma_regs u_spi_dma_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .start         (start),
        .length        (length),
        .tx_byte       (tx_byte),
        .tx_valid      (tx_valid),
        .rx_ready      (rx_ready),
        .tx_ready      (tx_ready),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .busy          (busy),
        .done          (done)
    );

    spi_byte_engine u_spi_byte_engine (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .start         (start),
        .length        (length),
        .tx_byte       (tx_byte),
        .tx_valid      (tx_valid),
        .rx_ready      (rx_ready),
        .tx_ready      (tx_ready),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .busy          (busy),
        .done          (done),
        .sclk          (sclk),
        .cs_n          (cs_n),
        .mosi          (mosi),
        .miso          (miso)
    );

endmodule

//--- verilog/spi_byte_engine.sv
// SPI mode 0 byte engine with transfer FSM, sclk generation, shift registers and counters
`timescale 1ns/1ps

module spi_byte_engine
    import spi_dma_pkg::*;
(
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,

    input  logic                start,
    input  logic [len_w-1:0]    length,
    input  logic [byte_w-1:0]   tx_byte,
    input  logic                tx_valid,
    input  logic                rx_ready,

    output logic                tx_ready,
    output logic [byte_w-1:0]   rx_byte,
    output logic                rx_valid,
    output logic                busy,
    output logic                done,

    output logic                sclk,
    output logic                cs_n,
    output logic                mosi,
    input  logic                miso
);

    spi_state_e           state;
    logic [byte_w-1:0]    tx_sr;
    logic [byte_w-1:0]    rx_sr;
    logic [bit_cnt_w-1:0] bit_cnt;
    logic [len_w-1:0]     byte_cnt;

    // MSB first
    assign mosi = tx_sr[byte_w-1];

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state    <= st_idle;
            tx_sr    <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rx_byte  <= '0;
            sclk     <= 1'b0;
            cs_n     <= 1'b1;
            tx_ready <= 1'b0;
            rx_valid <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // Zero length start is ignored, done stays as it was
                    if (start && (length != '0)) begin
                        byte_cnt <= length;
                        cs_n     <= 1'b0;
                        busy     <= 1'b1;
                        tx_ready <= 1'b1;
                        done     <= 1'b0;
                        state    <= st_load;
                    end
                end
                st_load: begin
                    if (tx_valid) begin
                        tx_sr    <= tx_byte;
                        bit_cnt  <= bit_cnt_w'(byte_w - 1);
                        tx_ready <= 1'b0;
                        state    <= st_shift;
                    end
                end
                st_shift: begin
                    sclk <= !sclk;
                    // Falling phase, advance to next bit
                    if (sclk) begin
                        tx_sr <= {tx_sr[byte_w-2:0], 1'b0};
                        if (bit_cnt == '0) begin
                            rx_byte  <= rx_sr;
                            rx_valid <= 1'b1;
                            state    <= st_store;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                st_store: begin
                    if (rx_ready) begin
                        rx_valid <= 1'b0;
                        byte_cnt <= byte_cnt - 1'b1;
                        if (byte_cnt == len_w'(1)) begin
                            state <= st_finish;
                        end else begin
                            tx_ready <= 1'b1;
                            state    <= st_load;
                        end
                    end
                end
                st_finish: begin
                    cs_n  <= 1'b1;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Rising phase sample, the edge that drives sclk high
    always_ff @(posedge S_AXI_ACLK) begin
        if ((state == st_shift) && !sclk) begin
            rx_sr <= {rx_sr[byte_w-2:0], miso};
        end
    end

endmodule

//--- verilog/spi_dma_regs.sv
// Control register write decode, start and valid pulses, status read multiplexer
`timescale 1ns/1ps

module spi_dma_regs
    import spi_dma_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,

    input  logic                   wr_en,
    input  reg_addr_e              wr_addr,
    input  logic [axil_data_w-1:0] wr_data,
    input  logic                   rd_en,
    input  reg_addr_e              rd_addr,
    output logic [axil_data_w-1:0] rd_data,

    output logic                   start,
    output logic [len_w-1:0]       length,
    output logic [byte_w-1:0]      tx_byte,
    output logic                   tx_valid,
    output logic                   rx_ready,

    input  logic                   tx_ready,
    input  logic [byte_w-1:0]      rx_byte,
    input  logic                   rx_valid,
    input  logic                   busy,
    input  logic                   done
);

    // Pulses last one cycle after the commit
    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            start    <= 1'b0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
            length   <= '0;
        end else begin
            start    <= wr_en && (wr_addr == addr_start) && wr_data[0];
            tx_valid <= wr_en && (wr_addr == addr_valid_in) && wr_data[0];
            if (wr_en && (wr_addr == addr_ready_in)) begin
                rx_ready <= wr_data[0];
            end
            if (wr_en && (wr_addr == addr_length)) begin
                length <= wr_data[len_w-1:0];
            end
        end
    end

    // Transmit byte holding register
    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_en && (wr_addr == addr_data_in)) begin
            tx_byte <= wr_data[byte_w-1:0];
        end
    end

    // Status is zero extended, write-only and unmapped addresses read zero
    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (rd_addr)
                addr_ready_out: rd_data = axil_data_w'(tx_ready);
                addr_data_out:  rd_data = axil_data_w'(rx_byte);
                addr_valid_out: rd_data = axil_data_w'(rx_valid);
                addr_length:    rd_data = axil_data_w'(length);
                addr_busy:      rd_data = axil_data_w'(busy);
                addr_done:      rd_data = axil_data_w'(done);
                default:        rd_data = '0;
            endcase
        end
    end

endmodule

//--- verilog/axil_slave_port.sv
// AXI4-Lite slave channel handshakes, register write strobe and read data return
`timescale 1ns/1ps

module axil_slave_port
    import spi_dma_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,

    input  logic [axil_addr_w-1:0] S_AXI_AWADDR,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    input  logic [axil_data_w-1:0] S_AXI_WDATA,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,

    input  logic [axil_addr_w-1:0] S_AXI_ARADDR,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    output logic [axil_data_w-1:0] S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY,

    output logic                   wr_en,
    output reg_addr_e              wr_addr,
    output logic [axil_data_w-1:0] wr_data,
    output logic                   rd_en,
    output reg_addr_e              rd_addr,
    input  logic [axil_data_w-1:0] rd_data
);

    logic aw_ready_q;
    logic ar_ready_q;

    // Address and data accepted together, one cycle wide
    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            aw_ready_q <= 1'b0;
        end else begin
            aw_ready_q <= !aw_ready_q && S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_BVALID;
        end
    end

    assign S_AXI_AWREADY = aw_ready_q;
    assign S_AXI_WREADY  = aw_ready_q;

    // Commit strobe toward the register block
    assign wr_en   = aw_ready_q && S_AXI_AWVALID && S_AXI_WVALID;
    assign wr_addr = reg_addr_e'(S_AXI_AWADDR);
    assign wr_data = S_AXI_WDATA;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_BVALID <= 1'b0;
        end else if (wr_en) begin
            S_AXI_BVALID <= 1'b1;
        end else if (S_AXI_BREADY) begin
            S_AXI_BVALID <= 1'b0;
        end
    end

    assign S_AXI_BRESP = axil_resp_okay;

    // Blocked while a read response is still pending
    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            ar_ready_q <= 1'b0;
        end else begin
            ar_ready_q <= !ar_ready_q && S_AXI_ARVALID && !S_AXI_RVALID;
        end
    end

    assign S_AXI_ARREADY = ar_ready_q;
    assign rd_en         = ar_ready_q && S_AXI_ARVALID;
    assign rd_addr       = reg_addr_e'(S_AXI_ARADDR);

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_RVALID <= 1'b0;
        end else if (rd_en) begin
            S_AXI_RVALID <= 1'b1;
        end else if (S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
        end
    end

    // Read data captured with the address handshake
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_en) begin
            S_AXI_RDATA <= rd_data;
        end
    end

    assign S_AXI_RRESP = axil_resp_okay;

endmodule

//--- verilog/spi_dma_pkg.sv
// Shared widths, AXI response code, register map enum and SPI engine state enum
package spi_dma_pkg;

    // AXI4-Lite bus widths
    localparam int axil_addr_w = 5;
    localparam int axil_data_w = 16;

    // SPI datapath widths
    localparam int byte_w    = 8;
    localparam int len_w     = 16;
    localparam int bit_cnt_w = 3;

    localparam logic [1:0] axil_resp_okay = 2'b00;

    // Register map, byte addresses on the AXI side
    typedef enum logic [axil_addr_w-1:0] {
        addr_data_in   = 5'h00,
        addr_valid_in  = 5'h02,
        addr_ready_out = 5'h04,
        addr_data_out  = 5'h06,
        addr_valid_out = 5'h08,
        addr_ready_in  = 5'h0A,
        addr_start     = 5'h0C,
        addr_length    = 5'h0E,
        addr_busy      = 5'h10,
        addr_done      = 5'h12
    } reg_addr_e;

    // Byte engine sequence
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_load   = 3'd1,
        st_shift  = 3'd2,
        st_store  = 3'd3,
        st_finish = 3'd4
    } spi_state_e;

endpackage
